// File: armCore.f
hw/armPkg.sv
hw/conditionCheck.sv
hw/aluUnit.sv
hw/regFile.sv
hw/armController.sv
hw/hazardUnit.sv
hw/datapath.sv
hw/armCore.sv
verification/armCoreTb.sv

// File: hw/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
  input  armPkg::wordT    srcA,
  input  armPkg::wordT    srcB,
  input  armPkg::aluCtrlT aluControl,
  input  logic            swap,
  input  logic            carryIn,
  output armPkg::wordT    result,
  output armPkg::flagsT   aluFlags
);
  import armPkg::*;

  wordT        opA, opB, addB;
  logic        isArith, invertB, cin;
  logic [32:0] sum;

  assign opA = swap ? srcB : srcA; // Reverse subtracts
  assign opB = swap ? srcA : srcB;

  always_comb begin
    isArith = 1'b1;
    invertB = 1'b0;
    cin     = 1'b0;
    case (aluControl)
      opSub, opRsb, opCmp: begin
        invertB = 1'b1;
        cin     = 1'b1;
      end
      opSbc, opRsc: begin
        invertB = 1'b1;
        cin     = carryIn; // Borrow is NOT carry
      end
      opAdc:        cin     = carryIn;
      opAdd, opCmn: cin     = 1'b0;
      default:      isArith = 1'b0;
    endcase
  end

  assign addB = invertB ? ~opB : opB;
  assign sum  = {1'b0, opA} + {1'b0, addB} + {32'd0, cin};

  always_comb begin
    case (aluControl)
      opAnd, opTst: result = opA & opB;
      opEor, opTeq: result = opA ^ opB;
      opOrr:        result = opA | opB;
      default:      result = isArith ? sum[31:0] : opB; // Other opcodes pass B
    endcase
  end

  assign aluFlags[3] = result[31];
  assign aluFlags[2] = (result == '0);
  assign aluFlags[1] = isArith & sum[32];
  assign aluFlags[0] = isArith & (opA[31] == addB[31]) & (sum[31] != opA[31]);

endmodule

// File: hw/armController.sv
`timescale 1ns/1ps

module armController (
  input  logic            clk,
  input  logic            rstN,
  input  armPkg::wordT    instrD,
  input  armPkg::flagsT   aluFlagsE,
  input  logic            flushE,
  output logic [1:0]      regSrcD,
  output logic [1:0]      immSrcD,
  output logic            aluSrcE,
  output armPkg::aluCtrlT aluControlE,
  output logic            swapE,
  output logic            carryInE,
  output logic            branchTakenE,
  output logic            memtoRegE,
  output logic            memWriteM,
  output logic            regWriteM,
  output logic            memtoRegW,
  output logic            pcSrcW,
  output logic            regWriteW,
  output logic            pcWrPendingF
);
  import armPkg::*;

  logic [9:0] controlsD;
  logic       aluSrcD, memtoRegD, tableWriteD, memWriteD, branchD, aluOpD;
  logic       unimplD, compareD, regWriteD, pcSrcD, swapD;
  aluCtrlT    aluControlD;
  logic [1:0] flagWriteD, flagWriteE;
  logic       branchE, memWriteE, regWriteE, pcSrcE, condExE;
  condT       condE;
  logic       memtoRegM, pcSrcM;

  always_comb begin
    unimplD = 1'b0;
    case (instrD[27:26])
      2'b00:   controlsD = instrD[25] ? 10'b00_00_1_0_1_0_0_1   // DP immediate
                                      : 10'b00_00_0_0_1_0_0_1;  // DP register
      2'b01:   controlsD = instrD[20] ? 10'b00_01_1_1_1_0_0_0   // LDR
                                      : 10'b10_01_1_0_0_1_0_0;  // STR
      2'b10:   controlsD = 10'b01_10_1_0_0_0_1_0;               // B
      default: begin
        controlsD = '0;
        unimplD   = 1'b1;
      end
    endcase
  end

  assign {regSrcD, immSrcD, aluSrcD, memtoRegD,
          tableWriteD, memWriteD, branchD, aluOpD} = controlsD;

  always_comb begin
    if (aluOpD) begin
      aluControlD = instrD[24:21];
    end else if (memWriteD || memtoRegD) begin
      aluControlD = instrD[23] ? opAdd : opSub; // U bit picks offset direction
    end else begin
      aluControlD = opAdd; // Branch target from PC+8
    end
  end

  assign compareD      = aluOpD & (aluControlD inside {opTst, opTeq, opCmp, opCmn});
  assign flagWriteD[1] = aluOpD & instrD[20];
  assign flagWriteD[0] = flagWriteD[1] & (aluControlD inside
                         {opSub, opRsb, opAdd, opAdc, opSbc, opRsc, opCmp, opCmn});
  assign swapD         = aluOpD & (aluControlD inside {opRsb, opRsc});

  // Destination r15 turns a register write into a PC load
  assign regWriteD = tableWriteD & ~compareD & (instrD[15:12] != 4'd15);
  assign pcSrcD    = tableWriteD & ~compareD & (instrD[15:12] == 4'd15);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      {flagWriteE, branchE, memWriteE, regWriteE, pcSrcE, memtoRegE} <= '0;
    end else if (flushE) begin
      {flagWriteE, branchE, memWriteE, regWriteE, pcSrcE, memtoRegE} <= '0;
    end else begin
      {flagWriteE, branchE, memWriteE, regWriteE, pcSrcE, memtoRegE} <=
        {flagWriteD, branchD, memWriteD, regWriteD, pcSrcD, memtoRegD};
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      {aluSrcE, aluControlE, swapE, condE} <= '0;
    end else begin
      {aluSrcE, aluControlE, swapE, condE} <= {aluSrcD, aluControlD, swapD, instrD[31:28]};
    end
  end

  conditionCheck condCheck (
    .clk        (clk),
    .rstN       (rstN),
    .condE      (condE),
    .flagWriteE (flagWriteE),
    .aluFlagsE  (aluFlagsE),
    .condExE    (condExE),
    .carryInE   (carryInE)
  );

  assign branchTakenE = branchE & condExE;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      {memWriteM, memtoRegM, regWriteM, pcSrcM} <= '0;
      {memtoRegW, regWriteW, pcSrcW} <= '0;
    end else begin
      memWriteM <= memWriteE & condExE;
      memtoRegM <= memtoRegE;
      regWriteM <= regWriteE & condExE;
      pcSrcM    <= pcSrcE & condExE;
      {memtoRegW, regWriteW, pcSrcW} <= {memtoRegM, regWriteM, pcSrcM};
    end
  end

  assign pcWrPendingF = pcSrcD | pcSrcE | pcSrcM; // PC writer still in flight

  // Undecoded classes that move on to execute must fail their condition
  assert property (@(posedge clk) disable iff (!rstN)
    (unimplD && !flushE) |=> !condExE)
    else $error("unimplemented instruction reached execute with its condition passing");

endmodule

// File: hw/armCore.sv
`timescale 1ns/1ps

module armCore #(
  parameter armPkg::wordT resetVector = 32'h0000_0000
) (
  input  logic         clk,
  input  logic         rstN,
  output armPkg::wordT pcF,
  input  armPkg::wordT instrF,
  output armPkg::wordT dataAdr,
  output armPkg::wordT writeData,
  output logic         memWrite,
  input  armPkg::wordT readData
);
  import armPkg::*;

  wordT    instrD;
  flagsT   aluFlagsE;
  aluCtrlT aluControlE;
  logic [1:0] regSrcD, immSrcD;
  logic    aluSrcE, swapE, carryInE, branchTakenE, memtoRegE;
  logic    regWriteM, memtoRegW, pcSrcW, regWriteW, pcWrPendingF;
  regAddrT ra1D, ra2D, ra1E, ra2E, wa3E, wa3M, wa3W;
  fwdSelT  fwdAE, fwdBE;
  logic    stallF, stallD, flushD, flushE;

  armController controller (
    .clk(clk), .rstN(rstN), .instrD(instrD), .aluFlagsE(aluFlagsE), .flushE(flushE),
    .regSrcD(regSrcD), .immSrcD(immSrcD), .aluSrcE(aluSrcE), .aluControlE(aluControlE),
    .swapE(swapE), .carryInE(carryInE), .branchTakenE(branchTakenE),
    .memtoRegE(memtoRegE), .memWriteM(memWrite), .regWriteM(regWriteM),
    .memtoRegW(memtoRegW), .pcSrcW(pcSrcW), .regWriteW(regWriteW),
    .pcWrPendingF(pcWrPendingF)
  );

  datapath #(
    .resetVector(resetVector)
  ) dp (
    .clk(clk), .rstN(rstN), .instrF(instrF),
    .regSrcD(regSrcD), .immSrcD(immSrcD), .aluSrcE(aluSrcE), .aluControlE(aluControlE),
    .swapE(swapE), .carryInE(carryInE), .branchTakenE(branchTakenE),
    .memtoRegW(memtoRegW), .pcSrcW(pcSrcW), .regWriteW(regWriteW),
    .readData(readData), .fwdAE(fwdAE), .fwdBE(fwdBE),
    .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE),
    .pcF(pcF), .instrD(instrD), .aluFlagsE(aluFlagsE),
    .dataAdr(dataAdr), .writeData(writeData),
    .ra1D(ra1D), .ra2D(ra2D), .ra1E(ra1E), .ra2E(ra2E),
    .wa3E(wa3E), .wa3M(wa3M), .wa3W(wa3W)
  );

  hazardUnit hazard (
    .ra1D(ra1D), .ra2D(ra2D), .ra1E(ra1E), .ra2E(ra2E),
    .wa3E(wa3E), .wa3M(wa3M), .wa3W(wa3W),
    .regWriteM(regWriteM), .regWriteW(regWriteW), .memtoRegE(memtoRegE),
    .pcWrPendingF(pcWrPendingF), .branchTakenE(branchTakenE), .pcSrcW(pcSrcW),
    .fwdAE(fwdAE), .fwdBE(fwdBE),
    .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE)
  );

endmodule

// File: hw/armPkg.sv
package armPkg;

  typedef logic [31:0] wordT;    // Data word, address or instruction
  typedef logic [3:0]  regAddrT;
  typedef logic [3:0]  flagsT;   // N Z C V from msb down
  typedef logic [3:0]  aluCtrlT; // Instruction bits 24..21
  typedef logic [3:0]  condT;
  typedef logic [1:0]  fwdSelT;

  // Data-processing opcodes as encoded in the instruction
  localparam aluCtrlT opAnd = 4'b0000;
  localparam aluCtrlT opEor = 4'b0001;
  localparam aluCtrlT opSub = 4'b0010;
  localparam aluCtrlT opRsb = 4'b0011;
  localparam aluCtrlT opAdd = 4'b0100;
  localparam aluCtrlT opAdc = 4'b0101;
  localparam aluCtrlT opSbc = 4'b0110;
  localparam aluCtrlT opRsc = 4'b0111;
  localparam aluCtrlT opTst = 4'b1000;
  localparam aluCtrlT opTeq = 4'b1001;
  localparam aluCtrlT opCmp = 4'b1010;
  localparam aluCtrlT opCmn = 4'b1011;
  localparam aluCtrlT opOrr = 4'b1100;

  localparam condT condAlways = 4'b1110;

  // Operand sources in execute
  localparam fwdSelT fwdReg = 2'b00; // Register file read in decode
  localparam fwdSelT fwdWb  = 2'b01;
  localparam fwdSelT fwdMem = 2'b10;

endpackage

// File: hw/conditionCheck.sv
`timescale 1ns/1ps

module conditionCheck (
  input  logic          clk,
  input  logic          rstN,
  input  armPkg::condT  condE,
  input  logic [1:0]    flagWriteE,
  input  armPkg::flagsT aluFlagsE,
  output logic          condExE,
  output logic          carryInE
);
  import armPkg::*;

  flagsT flags;
  logic  n, z, c, v, ge;

  assign {n, z, c, v} = flags;
  assign ge = (n == v);

  always_comb begin
    case (condE)
      4'b0000:    condExE = z;              // EQ
      4'b0001:    condExE = ~z;             // NE
      4'b0010:    condExE = c;              // CS
      4'b0011:    condExE = ~c;             // CC
      4'b0100:    condExE = n;              // MI
      4'b0101:    condExE = ~n;             // PL
      4'b0110:    condExE = v;              // VS
      4'b0111:    condExE = ~v;             // VC
      4'b1000:    condExE = c & ~z;         // HI
      4'b1001:    condExE = ~(c & ~z);      // LS
      4'b1010:    condExE = ge;             // GE
      4'b1011:    condExE = ~ge;            // LT
      4'b1100:    condExE = ~z & ge;        // GT
      4'b1101:    condExE = ~(~z & ge);     // LE
      condAlways: condExE = 1'b1;
      default:    condExE = 1'b0;           // Treated as never
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flags <= '0;
    end else begin
      if (flagWriteE[1] && condExE) begin
        flags[3:2] <= aluFlagsE[3:2]; // N and Z
      end
      if (flagWriteE[0] && condExE) begin
        flags[1:0] <= aluFlagsE[1:0]; // C and V
      end
    end
  end

  assign carryInE = c; // Stored carry feeds ADC SBC RSC

endmodule

// File: hw/datapath.sv
`timescale 1ns/1ps

module datapath #(
  parameter armPkg::wordT resetVector = 32'h0000_0000
) (
  input  logic            clk,
  input  logic            rstN,
  input  armPkg::wordT    instrF,
  input  logic [1:0]      regSrcD,
  input  logic [1:0]      immSrcD,
  input  logic            aluSrcE,
  input  armPkg::aluCtrlT aluControlE,
  input  logic            swapE,
  input  logic            carryInE,
  input  logic            branchTakenE,
  input  logic            memtoRegW,
  input  logic            pcSrcW,
  input  logic            regWriteW,
  input  armPkg::wordT    readData,
  input  armPkg::fwdSelT  fwdAE,
  input  armPkg::fwdSelT  fwdBE,
  input  logic            stallF,
  input  logic            stallD,
  input  logic            flushD,
  input  logic            flushE,
  output armPkg::wordT    pcF,
  output armPkg::wordT    instrD,
  output armPkg::flagsT   aluFlagsE,
  output armPkg::wordT    dataAdr,
  output armPkg::wordT    writeData,
  output armPkg::regAddrT ra1D,
  output armPkg::regAddrT ra2D,
  output armPkg::regAddrT ra1E,
  output armPkg::regAddrT ra2E,
  output armPkg::regAddrT wa3E,
  output armPkg::regAddrT wa3M,
  output armPkg::regAddrT wa3W
);
  import armPkg::*;

  localparam wordT bubbleInstr = 32'hF000_0000; // Condition never

  wordT    pcNext, pcPlus4F;
  wordT    extImmD, rd1D, rd2D;
  regAddrT wa3D;
  wordT    rd1E, rd2E, extImmE, srcAE, writeDataE, srcBE, aluResultE;
  wordT    aluResultM, writeDataM;
  wordT    aluResultW, readDataW, resultW;

  assign pcPlus4F = pcF + 32'd4;
  assign pcNext   = branchTakenE ? aluResultE : (pcSrcW ? resultW : pcPlus4F);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pcF <= resetVector;
    end else if (!stallF) begin
      pcF <= pcNext;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      instrD <= bubbleInstr;
    end else if (flushD) begin
      instrD <= bubbleInstr;
    end else if (!stallD) begin
      instrD <= instrF;
    end
  end

  assign ra1D = regSrcD[0] ? 4'd15 : instrD[19:16]; // Branch reads the PC
  assign ra2D = regSrcD[1] ? instrD[15:12] : instrD[3:0]; // STR reads Rd
  assign wa3D = instrD[15:12];

  always_comb begin
    case (immSrcD)
      2'b00:   extImmD = {24'd0, instrD[7:0]};
      2'b01:   extImmD = {20'd0, instrD[11:0]};
      default: extImmD = {{6{instrD[23]}}, instrD[23:0], 2'b00}; // Word branch offset
    endcase
  end

  regFile rf (
    .clk  (clk),
    .rstN (rstN),
    .we3  (regWriteW),
    .ra1  (ra1D),
    .ra2  (ra2D),
    .wa3  (wa3W),
    .wd3  (resultW),
    .r15  (pcPlus4F),
    .rd1  (rd1D),
    .rd2  (rd2D)
  );

  always_ff @(posedge clk) begin
    rd1E    <= rd1D;
    rd2E    <= rd2D;
    extImmE <= extImmD;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      {ra1E, ra2E, wa3E} <= '0;
    end else if (flushE) begin
      {ra1E, ra2E, wa3E} <= '0; // Bubble matches nothing useful
    end else begin
      {ra1E, ra2E, wa3E} <= {ra1D, ra2D, wa3D};
    end
  end

  always_comb begin
    case (fwdAE)
      fwdMem:  srcAE = aluResultM;
      fwdWb:   srcAE = resultW;
      default: srcAE = rd1E;
    endcase
    case (fwdBE)
      fwdMem:  writeDataE = aluResultM;
      fwdWb:   writeDataE = resultW;
      default: writeDataE = rd2E;
    endcase
  end

  assign srcBE = aluSrcE ? extImmE : writeDataE;

  aluUnit alu (
    .srcA       (srcAE),
    .srcB       (srcBE),
    .aluControl (aluControlE),
    .swap       (swapE),
    .carryIn    (carryInE),
    .result     (aluResultE),
    .aluFlags   (aluFlagsE)
  );

  always_ff @(posedge clk) begin
    aluResultM <= aluResultE;
    writeDataM <= writeDataE;
    aluResultW <= aluResultM;
    readDataW  <= readData;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wa3M <= '0;
      wa3W <= '0;
    end else begin
      wa3M <= wa3E;
      wa3W <= wa3M;
    end
  end

  assign dataAdr   = aluResultM;
  assign writeData = writeDataM;
  assign resultW   = memtoRegW ? readDataW : aluResultW;

endmodule

// File: hw/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
  input  armPkg::regAddrT ra1D,
  input  armPkg::regAddrT ra2D,
  input  armPkg::regAddrT ra1E,
  input  armPkg::regAddrT ra2E,
  input  armPkg::regAddrT wa3E,
  input  armPkg::regAddrT wa3M,
  input  armPkg::regAddrT wa3W,
  input  logic            regWriteM,
  input  logic            regWriteW,
  input  logic            memtoRegE,
  input  logic            pcWrPendingF,
  input  logic            branchTakenE,
  input  logic            pcSrcW,
  output armPkg::fwdSelT  fwdAE,
  output armPkg::fwdSelT  fwdBE,
  output logic            stallF,
  output logic            stallD,
  output logic            flushD,
  output logic            flushE
);
  import armPkg::*;

  logic ldStall;

  // Memory stage holds the newer value
  assign fwdAE = (regWriteM && (ra1E == wa3M)) ? fwdMem :
                 (regWriteW && (ra1E == wa3W)) ? fwdWb : fwdReg;
  assign fwdBE = (regWriteM && (ra2E == wa3M)) ? fwdMem :
                 (regWriteW && (ra2E == wa3W)) ? fwdWb : fwdReg;

  assign ldStall = memtoRegE & ((ra1D == wa3E) | (ra2D == wa3E)); // Load result not ready

  assign stallF = ldStall | (pcWrPendingF & ~branchTakenE); // Taken branch must still load PC
  assign stallD = ldStall;
  assign flushD = branchTakenE | pcSrcW | (pcWrPendingF & ~ldStall);
  assign flushE = ldStall | branchTakenE;

  // A load in execute never coincides with a taken branch or a PC load in writeback
  always_comb begin
    assert final (!(stallD && flushD))
      else $error("decode stalled and flushed in the same cycle");
  end

endmodule

// File: hw/regFile.sv
`timescale 1ns/1ps

module regFile (
  input  logic            clk,
  input  logic            rstN,
  input  logic            we3,
  input  armPkg::regAddrT ra1,
  input  armPkg::regAddrT ra2,
  input  armPkg::regAddrT wa3,
  input  armPkg::wordT    wd3,
  input  armPkg::wordT    r15,
  output armPkg::wordT    rd1,
  output armPkg::wordT    rd2
);
  import armPkg::*;

  wordT regs [0:14]; // r0 to r14

  // Falling edge write lets decode read the result in the same cycle
  always_ff @(negedge clk) begin
    if (we3) begin
      regs[wa3] <= wd3;
    end
  end

  assign rd1 = (ra1 == 4'd15) ? r15 : regs[ra1]; // r15 reads as PC+8
  assign rd2 = (ra2 == 4'd15) ? r15 : regs[ra2];

  // The controller turns r15 writes into PC loads
  assert property (@(negedge clk) disable iff (!rstN)
    we3 |-> (wa3 != 4'd15))
    else $error("register write targets r15");

endmodule

// File: runSim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert \
    -f armCore.f \
    --top-module armCoreTb \
    -o armCoreSim &&
  ./obj_dir/armCoreSim ||
  { echo "Simulation run did not complete cleanly"; exit 1; }

// File: verification/armCoreCases.mem
// Words 00-3F: program, four instruction words per line starting at byte address 0
// Word 40: number of expected stores; words 41 on: pairs of store address then store data
@00
E2000000 E2801005 E2812003 E0813002
E2434001 E3845031 E0256003 E0067005
E0458004 E5803000 E5804004 E5805008
E580600C E5807010 E5808014 E3510005
05801018 1580201C 8580201C 9580201C
E3510009 A5803020 B5803020 15804024
E0819001 B5809028 8580902C E240A001
E29AB002 E2A1C003 E2C1D002 E261E014
E2E1901E E580B030 E580C034 E580D038
E580E03C E5809040 E3510009 E2A19003
E2C1B002 E5809044 E580B048 E2801055
E5801080 E5902080 E2823001 E580304C
E5904080 E5804050 EA000001 E5801054
E5801058 E3500001 0A000001 E5802054
E28FF004 E5803058 E580305C E5803060
EAFFFFFE
@40
00000017
// Forwarded arithmetic and logic results
00000000 0000000D  00000004 0000000C  00000008 0000003D
0000000C 00000030  00000010 00000030  00000014 00000031
// Conditional stores after CMP
00000018 00000005  0000001C 00000008  00000020 0000000D
00000024 0000000C  00000028 0000000A
// Carry in and reverse subtracts
00000030 00000001  00000034 00000009  00000038 00000003
0000003C 0000000F  00000040 00000019  00000044 00000008
00000048 00000002
// Store, load and load-use
00000080 00000055  0000004C 00000056  00000050 00000055
// Not-taken branch falls through, PC write lands here
00000054 00000055  00000060 00000056

// File: verification/armCoreTb.sv
`timescale 1ns/1ps

module armCoreTb;
  import armPkg::*;

  localparam int progWords     = 64; // Program region of the case file
  localparam int countIdx      = 64;
  localparam int pairBase      = 65; // Address then data per store
  localparam int caseDepth     = 160;
  localparam int resetCycles   = 16;
  localparam int cyclesPerWord = 20;
  localparam wordT resetVec    = 32'h0000_0000;

  logic clk;
  logic rstN;
  wordT pcF;
  wordT instrF;
  wordT dataAdr;
  wordT writeData;
  logic memWrite;
  wordT readData;

  wordT   caseMem [0:caseDepth-1];
  wordT   dataMem [0:63];
  integer seed = 32'h6a915786;
  int     storeCount;
  int     storeIdx;
  int     progLen;

  armCore #(
    .resetVector(resetVec)
  ) dut (
    .clk       (clk),
    .rstN      (rstN),
    .pcF       (pcF),
    .instrF    (instrF),
    .dataAdr   (dataAdr),
    .writeData (writeData),
    .memWrite  (memWrite),
    .readData  (readData)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Instruction memory, never-condition word outside the program
  always_comb begin
    instrF = (pcF[31:8] == 24'd0) ? caseMem[pcF[7:2]] : 32'hF000_0000;
  end

  always_comb begin
    readData = dataMem[dataAdr[7:2]];
  end

  // Store lands on the rising edge that ends the strobe cycle
  always @(posedge clk) begin
    if (rstN && memWrite && (dataAdr[31:8] == 24'd0)) begin
      dataMem[dataAdr[7:2]] <= writeData;
    end
  end

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  // Outputs come from stage registers, stable at the falling edge
  always @(negedge clk) begin
    if (rstN && memWrite) begin
      if ((dataAdr[31:8] != 24'd0) || (dataAdr[1:0] != 2'd0)) begin
        failRun($sformatf("Store address %h lies outside the data memory", dataAdr));
      end else begin
        assert ((dataAdr == caseMem[pairBase + 2 * storeIdx]) &&
                (writeData == caseMem[pairBase + 2 * storeIdx + 1]))
          else failRun($sformatf("ERROR: time %0t: store %0d wrote %h to %h, expected %h to %h",
                                 $time, storeIdx, writeData, dataAdr,
                                 caseMem[pairBase + 2 * storeIdx + 1],
                                 caseMem[pairBase + 2 * storeIdx]));
        storeIdx = storeIdx + 1;
        if (storeIdx == storeCount) begin
          $display("Result: PASSED");
          $finish;
        end
      end
    end
  end

  initial begin
    rstN = 1'b0;
    storeIdx = 0;
    progLen = 0;
    for (int i = 0; i < caseDepth; i++) begin
      caseMem[i] = '0;
    end
    $readmemh("verification/armCoreCases.mem", caseMem);
    for (int i = 0; i < 64; i++) begin
      dataMem[i] = $random(seed); // Program reads only words it stored first
    end
    storeCount = int'(caseMem[countIdx]);
    for (int i = 0; i < progWords; i++) begin
      if (caseMem[i] != '0) begin
        progLen = progLen + 1;
      end
    end
    if ((storeCount == 0) || (pairBase + 2 * storeCount > caseDepth)) begin
      failRun("The case file holds no usable list of expected stores");
    end else begin
      repeat (resetCycles) @(posedge clk);
      // PC sits at the reset vector with no store strobe
      assert ((pcF == resetVec) && !memWrite)
        else failRun($sformatf("ERROR: time %0t: in reset pcF is %h and memWrite is %b",
                               $time, pcF, memWrite));
      rstN <= 1'b1;
      // Watchdog
      repeat (cyclesPerWord * progLen) @(posedge clk);
      failRun($sformatf("Timeout: only %0d of %0d expected stores appeared",
                        storeIdx, storeCount));
    end
  end

endmodule
